/* logic/isa_pkg.sv */
package isa_pkg;

    // architectural widths
    localparam int data_w  = 32;
    localparam int addr_w  = 32;
    localparam int regnm_w = 5;

    // instruction class as recorded at dispatch
    typedef enum logic [2:0] {
        op_alu    = 3'd0,
        op_branch = 3'd1,
        op_jump   = 3'd2,
        op_load   = 3'd3,
        op_store  = 3'd4
    } op_class_e;

endpackage

/* logic/rob_pkg.sv */
package rob_pkg;

    // buffer geometry
    localparam int rob_depth = 16;
    localparam int tag_w     = 4;
    // one bit wider than the tag so a full buffer is representable
    localparam int count_w   = 5;

    // what the head entry does in the current cycle
    typedef enum logic [1:0] {
        commit_none     = 2'd0,
        commit_reg      = 2'd1,
        commit_store    = 2'd2,
        commit_redirect = 2'd3
    } commit_kind_e;

endpackage

/* logic/rob_control.sv */
`timescale 1ns/1ps

module rob_control
    import rob_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             alloc_req,
    input  logic             head_ready,
    input  logic             head_is_store,
    input  logic             head_mispredict,
    output logic             alloc_grant,
    output logic [tag_w-1:0] alloc_tag,
    output logic             full,
    output logic [tag_w-1:0] head_tag,
    output commit_kind_e     commit_kind
);

    logic [tag_w-1:0]   head_ptr;
    logic [tag_w-1:0]   tail_ptr;
    logic [count_w-1:0] count;

    logic               empty;
    logic               retire;
    logic               flush;
    logic [tag_w-1:0]   head_next;
    logic [tag_w-1:0]   tail_next;

    assign empty = (count == count_w'(0));
    assign full  = (count == count_w'(rob_depth));

    // pointers wrap naturally at rob_depth
    assign head_next = head_ptr + tag_w'(1);
    assign tail_next = tail_ptr + tag_w'(1);

    // commit decision, store first, then redirect, then plain register
    always_comb begin
        commit_kind = commit_none;
        if (!empty && head_ready) begin
            if (head_is_store) begin
                commit_kind = commit_store;
            end else if (head_mispredict) begin
                commit_kind = commit_redirect;
            end else begin
                commit_kind = commit_reg;
            end
        end
    end

    assign retire = (commit_kind != commit_none);
    assign flush  = (commit_kind == commit_redirect);

    // no new entries while the buffer is being emptied
    assign alloc_grant = alloc_req && !full && !flush;
    assign alloc_tag   = tail_ptr;
    assign head_tag    = head_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush) begin
            // everything younger than the head is discarded
            head_ptr <= head_next;
            tail_ptr <= head_next;
            count    <= '0;
        end else begin
            if (alloc_grant) begin
                tail_ptr <= tail_next;
            end
            if (retire) begin
                head_ptr <= head_next;
            end
            // allocate and retire in the same cycle leave the count unchanged
            count <= count + count_w'(alloc_grant) - count_w'(retire);
        end
    end

endmodule

/* logic/rob_entry_store.sv */
`timescale 1ns/1ps

module rob_entry_store
    import isa_pkg::*;
    import rob_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               alloc_grant,
    input  logic [tag_w-1:0]   alloc_tag,
    input  logic [regnm_w-1:0] alloc_regnm,
    input  logic               disp_en,
    input  logic [tag_w-1:0]   disp_tag,
    input  op_class_e          disp_op,
    input  logic               disp_pred_taken,
    input  logic               ex_en,
    input  logic [tag_w-1:0]   ex_tag,
    input  logic [data_w-1:0]  ex_data,
    input  logic               ex_taken,
    input  logic [addr_w-1:0]  ex_target,
    input  logic               lsu_en,
    input  logic [tag_w-1:0]   lsu_tag,
    input  logic [data_w-1:0]  lsu_data,
    input  logic [tag_w-1:0]   head_tag,
    output logic               head_ready,
    output logic               head_is_store,
    output logic               head_mispredict,
    output logic [regnm_w-1:0] head_regnm,
    output logic [data_w-1:0]  head_data,
    output logic [addr_w-1:0]  head_target
);

    // payload, indexed by tag
    logic [regnm_w-1:0]   regnm_mem  [rob_depth];
    op_class_e            op_mem     [rob_depth];
    logic                 pred_mem   [rob_depth];
    logic                 taken_mem  [rob_depth];
    logic [data_w-1:0]    data_mem   [rob_depth];
    logic [addr_w-1:0]    target_mem [rob_depth];

    logic [rob_depth-1:0] disp_q;
    logic [rob_depth-1:0] done_q;

    op_class_e            head_op;
    logic                 head_is_ctrl;

    // status flags, a fresh allocation starts the entry over
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            disp_q <= '0;
            done_q <= '0;
        end else begin
            if (alloc_grant) begin
                disp_q[alloc_tag] <= 1'b0;
                done_q[alloc_tag] <= 1'b0;
            end
            if (disp_en) begin
                disp_q[disp_tag] <= 1'b1;
            end
            if (ex_en) begin
                done_q[ex_tag] <= 1'b1;
            end
            if (lsu_en) begin
                done_q[lsu_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_grant) begin
            regnm_mem[alloc_tag] <= alloc_regnm;
        end
        if (disp_en) begin
            op_mem[disp_tag]   <= disp_op;
            pred_mem[disp_tag] <= disp_pred_taken;
        end
        if (ex_en) begin
            data_mem[ex_tag]   <= ex_data;
            taken_mem[ex_tag]  <= ex_taken;
            target_mem[ex_tag] <= ex_target;
        end
        // loads never redirect
        if (lsu_en) begin
            data_mem[lsu_tag]  <= lsu_data;
            taken_mem[lsu_tag] <= 1'b0;
        end
    end

    // head read port
    assign head_op      = op_mem[head_tag];
    assign head_is_ctrl = (head_op == op_branch) || (head_op == op_jump);

    // stores retire on dispatch alone
    assign head_is_store   = disp_q[head_tag] && (head_op == op_store);
    assign head_ready      = done_q[head_tag] || head_is_store;
    assign head_mispredict = disp_q[head_tag] && head_is_ctrl &&
                             (pred_mem[head_tag] != taken_mem[head_tag]);

    assign head_regnm  = regnm_mem[head_tag];
    assign head_data   = data_mem[head_tag];
    assign head_target = target_mem[head_tag];

endmodule

/* logic/rob_commit_stage.sv */
`timescale 1ns/1ps

module rob_commit_stage
    import isa_pkg::*;
    import rob_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  commit_kind_e       commit_kind,
    input  logic [tag_w-1:0]   head_tag,
    input  logic [regnm_w-1:0] head_regnm,
    input  logic [data_w-1:0]  head_data,
    input  logic [addr_w-1:0]  head_target,
    output logic               rf_we,
    output logic [regnm_w-1:0] rf_regnm,
    output logic [data_w-1:0]  rf_data,
    output logic [tag_w-1:0]   rf_tag,
    output logic               store_release,
    output logic [tag_w-1:0]   store_tag,
    output logic               redirect,
    output logic [addr_w-1:0]  redirect_pc
);

    logic writes_reg;

    // a redirect still writes the link register
    assign writes_reg = (commit_kind == commit_reg) || (commit_kind == commit_redirect);

    // one-cycle pulses
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rf_we         <= 1'b0;
            store_release <= 1'b0;
            redirect      <= 1'b0;
        end else begin
            rf_we         <= writes_reg;
            store_release <= (commit_kind == commit_store);
            redirect      <= (commit_kind == commit_redirect);
        end
    end

    // payload holds its value between pulses
    always_ff @(posedge clk) begin
        if (writes_reg) begin
            rf_regnm <= head_regnm;
            rf_data  <= head_data;
            rf_tag   <= head_tag;
        end
        if (commit_kind == commit_store) begin
            store_tag <= head_tag;
        end
        if (commit_kind == commit_redirect) begin
            redirect_pc <= head_target;
        end
    end

endmodule

/* logic/rob_top.sv */
`timescale 1ns/1ps

module rob_top
    import isa_pkg::*;
    import rob_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    // allocation
    input  logic               alloc_req,
    input  logic [regnm_w-1:0] alloc_regnm,
    output logic               alloc_grant,
    output logic [tag_w-1:0]   alloc_tag,
    output logic               full,
    // dispatch
    input  logic               disp_en,
    input  logic [tag_w-1:0]   disp_tag,
    input  op_class_e          disp_op,
    input  logic               disp_pred_taken,
    // execute writeback
    input  logic               ex_en,
    input  logic [tag_w-1:0]   ex_tag,
    input  logic [data_w-1:0]  ex_data,
    input  logic               ex_taken,
    input  logic [addr_w-1:0]  ex_target,
    // load/store writeback
    input  logic               lsu_en,
    input  logic [tag_w-1:0]   lsu_tag,
    input  logic [data_w-1:0]  lsu_data,
    // commit
    output logic               rf_we,
    output logic [regnm_w-1:0] rf_regnm,
    output logic [data_w-1:0]  rf_data,
    output logic [tag_w-1:0]   rf_tag,
    output logic               store_release,
    output logic [tag_w-1:0]   store_tag,
    output logic               redirect,
    output logic [addr_w-1:0]  redirect_pc
);

    logic               head_ready;
    logic               head_is_store;
    logic               head_mispredict;
    logic [tag_w-1:0]   head_tag;
    logic [regnm_w-1:0] head_regnm;
    logic [data_w-1:0]  head_data;
    logic [addr_w-1:0]  head_target;
    commit_kind_e       commit_kind;

    rob_control rob_control_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .alloc_req       (alloc_req),
        .head_ready      (head_ready),
        .head_is_store   (head_is_store),
        .head_mispredict (head_mispredict),
        .alloc_grant     (alloc_grant),
        .alloc_tag       (alloc_tag),
        .full            (full),
        .head_tag        (head_tag),
        .commit_kind     (commit_kind)
    );

    rob_entry_store rob_entry_store_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .alloc_grant     (alloc_grant),
        .alloc_tag       (alloc_tag),
        .alloc_regnm     (alloc_regnm),
        .disp_en         (disp_en),
        .disp_tag        (disp_tag),
        .disp_op         (disp_op),
        .disp_pred_taken (disp_pred_taken),
        .ex_en           (ex_en),
        .ex_tag          (ex_tag),
        .ex_data         (ex_data),
        .ex_taken        (ex_taken),
        .ex_target       (ex_target),
        .lsu_en          (lsu_en),
        .lsu_tag         (lsu_tag),
        .lsu_data        (lsu_data),
        .head_tag        (head_tag),
        .head_ready      (head_ready),
        .head_is_store   (head_is_store),
        .head_mispredict (head_mispredict),
        .head_regnm      (head_regnm),
        .head_data       (head_data),
        .head_target     (head_target)
    );

    rob_commit_stage rob_commit_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .commit_kind   (commit_kind),
        .head_tag      (head_tag),
        .head_regnm    (head_regnm),
        .head_data     (head_data),
        .head_target   (head_target),
        .rf_we         (rf_we),
        .rf_regnm      (rf_regnm),
        .rf_data       (rf_data),
        .rf_tag        (rf_tag),
        .store_release (store_release),
        .store_tag     (store_tag),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc)
    );

endmodule

/* verification/rob_chk.sv */
`timescale 1ns/1ps

module rob_chk
    import rob_pkg::*;
(
    input logic               clk,
    input logic               rst_n,
    input logic               alloc_grant,
    input logic               full,
    input logic [count_w-1:0] count,
    input commit_kind_e       commit_kind
);

    // a full buffer hands out no tag
    grant_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_grant |-> !full)
        else $error("allocation granted while the buffer is full");

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= count_w'(rob_depth))
        else $error("occupancy count above buffer depth");

    // redirect empties the buffer at the retiring edge
    empty_after_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        (commit_kind == commit_redirect) |=> (count == '0))
        else $error("buffer not empty after a redirect commit");

    quiet_after_reset: assert property (@(posedge clk)
        !rst_n |=> (count == '0 && !full && commit_kind == commit_none))
        else $error("control outputs active right after reset");

endmodule

bind rob_control rob_chk rob_chk_inst (.*);

/* verification/rob_tb.sv */
`timescale 1ns/1ps

module rob_tb
    import isa_pkg::*;
    import rob_pkg::*;
;

    localparam int wait_limit = 100;
    localparam int num_rows   = 6;

    typedef struct {
        op_class_e          op;
        logic [regnm_w-1:0] regnm;
        logic [data_w-1:0]  data;
        logic               pred;
        logic               taken;
        logic [addr_w-1:0]  target;
        commit_kind_e       kind;
    } row_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               alloc_req;
    logic [regnm_w-1:0] alloc_regnm;
    logic               alloc_grant;
    logic [tag_w-1:0]   alloc_tag;
    logic               full;
    logic               disp_en;
    logic [tag_w-1:0]   disp_tag;
    op_class_e          disp_op;
    logic               disp_pred_taken;
    logic               ex_en;
    logic [tag_w-1:0]   ex_tag;
    logic [data_w-1:0]  ex_data;
    logic               ex_taken;
    logic [addr_w-1:0]  ex_target;
    logic               lsu_en;
    logic [tag_w-1:0]   lsu_tag;
    logic [data_w-1:0]  lsu_data;
    logic               rf_we;
    logic [regnm_w-1:0] rf_regnm;
    logic [data_w-1:0]  rf_data;
    logic [tag_w-1:0]   rf_tag;
    logic               store_release;
    logic [tag_w-1:0]   store_tag;
    logic               redirect;
    logic [addr_w-1:0]  redirect_pc;

    row_t               rows [num_rows];
    logic [tag_w-1:0]   row_tag [num_rows];
    logic [tag_w-1:0]   next_tag;
    logic [tag_w-1:0]   fill_tag;
    logic [tag_w-1:0]   first_fill_tag;
    logic [tag_w-1:0]   late_tag;
    int                 errors = 0;
    int                 timeouts = 0;

    rob_top rob_top_inst (.*);

    always #4 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic request_tag(input logic [regnm_w-1:0] regnm);
        @(posedge clk);
        alloc_req   <= 1'b1;
        alloc_regnm <= regnm;
    endtask

    // returns at the falling edge where the grant is seen
    task automatic wait_grant(output logic [tag_w-1:0] tag);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!alloc_grant && n < wait_limit);
        if (!alloc_grant) begin
            timeouts++;
            $display("timeout: allocation request was never granted");
        end
        tag = alloc_tag;
        check_value("alloc_tag", 32'(alloc_tag), 32'(next_tag));
        next_tag = next_tag + tag_w'(1);
    endtask

    task automatic drop_request();
        @(posedge clk);
        alloc_req <= 1'b0;
    endtask

    task automatic alloc_entry(input logic [regnm_w-1:0] regnm, output logic [tag_w-1:0] tag);
        request_tag(regnm);
        wait_grant(tag);
        drop_request();
    endtask

    task automatic dispatch(input logic [tag_w-1:0] tag, input op_class_e op, input logic pred);
        @(posedge clk);
        disp_en         <= 1'b1;
        disp_tag        <= tag;
        disp_op         <= op;
        disp_pred_taken <= pred;
        @(posedge clk);
        disp_en <= 1'b0;
    endtask

    // loads go through the load/store port, the rest through execute
    task automatic write_back(input logic [tag_w-1:0] tag, input row_t r);
        @(posedge clk);
        if (r.op == op_load) begin
            lsu_en   <= 1'b1;
            lsu_tag  <= tag;
            lsu_data <= r.data;
        end else begin
            ex_en     <= 1'b1;
            ex_tag    <= tag;
            ex_data   <= r.data;
            ex_taken  <= r.taken;
            ex_target <= r.target;
        end
        @(posedge clk);
        ex_en  <= 1'b0;
        lsu_en <= 1'b0;
    endtask

    task automatic expect_commit(input row_t r, input logic [tag_w-1:0] tag);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(rf_we || store_release) && n < wait_limit);
        if (!(rf_we || store_release)) begin
            timeouts++;
            $display("timeout: entry with tag %0d never committed", tag);
        end else begin
            check_value("rf_we", 32'(rf_we), 32'(r.kind != commit_store));
            check_value("store_release", 32'(store_release), 32'(r.kind == commit_store));
            check_value("redirect", 32'(redirect), 32'(r.kind == commit_redirect));
            if (r.kind == commit_store) begin
                check_value("store_tag", 32'(store_tag), 32'(tag));
            end else begin
                check_value("rf_regnm", 32'(rf_regnm), 32'(r.regnm));
                check_value("rf_data", rf_data, r.data);
                check_value("rf_tag", 32'(rf_tag), 32'(tag));
            end
            if (r.kind == commit_redirect) begin
                check_value("redirect_pc", redirect_pc, r.target);
            end
        end
    endtask

    initial begin
        rst_n           = 1'b0;
        alloc_req       = 1'b0;
        alloc_regnm     = '0;
        disp_en         = 1'b0;
        disp_tag        = '0;
        disp_op         = op_alu;
        disp_pred_taken = 1'b0;
        ex_en           = 1'b0;
        ex_tag          = '0;
        ex_data         = '0;
        ex_taken        = 1'b0;
        ex_target       = '0;
        lsu_en          = 1'b0;
        lsu_tag         = '0;
        lsu_data        = '0;

        // class, rd, result, predicted, actual, target, expected commit
        rows[0] = '{op_alu,    5'd1, 32'h0000_1111, 1'b0, 1'b0, 32'h0,    commit_reg};
        rows[1] = '{op_load,   5'd2, 32'h0000_2222, 1'b0, 1'b0, 32'h0,    commit_reg};
        rows[2] = '{op_store,  5'd0, 32'h0,         1'b0, 1'b0, 32'h0,    commit_store};
        rows[3] = '{op_branch, 5'd3, 32'h0000_3333, 1'b1, 1'b1, 32'h100,  commit_reg};
        rows[4] = '{op_jump,   5'd1, 32'h0000_4444, 1'b0, 1'b1, 32'h200,  commit_redirect};
        rows[5] = '{op_alu,    5'd5, 32'h0000_5555, 1'b0, 1'b0, 32'h0,    commit_none};

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("full after reset", 32'(full), 32'd0);
        check_value("rf_we after reset", 32'(rf_we), 32'd0);
        check_value("store_release after reset", 32'(store_release), 32'd0);
        check_value("redirect after reset", 32'(redirect), 32'd0);
        next_tag = '0;

        for (int i = 0; i < num_rows; i++) begin
            alloc_entry(rows[i].regnm, row_tag[i]);
            dispatch(row_tag[i], rows[i].op, rows[i].pred);
        end
        // youngest first and skipping the store
        for (int i = num_rows - 1; i >= 0; i--) begin
            if (rows[i].op != op_store) begin
                write_back(row_tag[i], rows[i]);
            end
        end
        for (int i = 0; i < num_rows; i++) begin
            if (rows[i].kind != commit_none) begin
                expect_commit(rows[i], row_tag[i]);
            end
        end
        // flushed rows must stay silent
        repeat (4) begin
            @(negedge clk);
            check_value("commit after redirect", 32'(rf_we || store_release), 32'd0);
        end

        // buffer restarts right behind the jump
        next_tag = row_tag[4] + tag_w'(1);
        for (int i = 0; i < rob_depth; i++) begin
            alloc_entry(regnm_w'(i), fill_tag);
            if (i == 0) begin
                first_fill_tag = fill_tag;
            end
        end
        @(negedge clk);
        check_value("full after sixteen grants", 32'(full), 32'd1);

        request_tag(5'd31);
        repeat (2) begin
            @(negedge clk);
            check_value("grant while full", 32'(alloc_grant), 32'd0);
        end
        dispatch(first_fill_tag, op_alu, 1'b0);
        write_back(first_fill_tag, rows[0]);
        wait_grant(late_tag);
        // the held request reuses the slot that was just freed
        check_value("tag of the held request", 32'(late_tag), 32'(first_fill_tag));
        check_value("rf_we with freed entry", 32'(rf_we), 32'd1);
        check_value("rf_tag with freed entry", 32'(rf_tag), 32'(first_fill_tag));
        check_value("rf_data with freed entry", rf_data, rows[0].data);
        drop_request();

        @(posedge clk);
        $display("errors=%0d timeouts=%0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* all.f */
logic/isa_pkg.sv
logic/rob_pkg.sv
logic/rob_control.sv
logic/rob_entry_store.sv
logic/rob_commit_stage.sv
logic/rob_top.sv
verification/rob_chk.sv
verification/rob_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rob_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
